//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_zclk
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@echo "simulation ok"

clean:
	rm -rf obj_dir $(LOG)

//--- clk_phase_gen.sv
// phase generator
// divides the 28 MHz clk into four rotating one-cycle strobes c0..c3,
// giving the 7 MHz timing grid for the z80 clock

`timescale 1ns/1ps

module clk_phase_gen (
	input  logic clk,
	input  logic arst_n,
	phase_if.src ph
);

	// free running phase counter
	logic [1:0] phase_cnt;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			phase_cnt <= 2'd0;
		else
			phase_cnt <= phase_cnt + 2'd1;
	end

	// decode, c0 first after reset
	assign ph.c0 = (phase_cnt == 2'd0);
	assign ph.c1 = (phase_cnt == 2'd1);
	assign ph.c2 = (phase_cnt == 2'd2);
	assign ph.c3 = (phase_cnt == 2'd3);

	// one strobe at a time, stepping c0 c1 c2 c3 once per clk
	a_phase_order: assert property (
		@(posedge clk) disable iff (!arst_n)
		1'b1 |=> $onehot({ph.c0, ph.c1, ph.c2, ph.c3})
			&& ({ph.c1, ph.c2, ph.c3, ph.c0} == $past({ph.c0, ph.c1, ph.c2, ph.c3}))
	);

endmodule

//--- phase_if.sv
// phase strobe bundle
// four one-hot strobes c0..c3, one clk cycle each, period of 4 clk
// from the phase generator to the z80 clock generator

`timescale 1ns/1ps

interface phase_if;

	// one-hot, order c0 c1 c2 c3
	logic c0;
	logic c1;
	logic c2;
	logic c3;

	// generator side drives every strobe
	modport src (
		output c0, c1, c2, c3
	);

	// clock generator only needs c0 and c2
	modport dst (
		input c0, c2
	);

endinterface

//--- tb.f
zclk_pkg.sv
phase_if.sv
clk_phase_gen.sv
turbo_sel.sv
wait_gen.sv
zclock.sv
zclk_top.sv
tb_zclk.sv

//--- tb_zclk.sv
// z80 clock subsystem testbench
// directed tests for speed modes, refresh-timed turbo switch,
// external, dos and i/o stalls, plus a monitor on zpos/zneg vs zclk_out

`timescale 1ns/1ps

module tb_zclk
	import zclk_pkg::*;
;

	localparam int zpos_timeout = 64;

	logic   clk = 1'b0;
	logic   arst_n;
	turbo_t turbo_req;
	logic   rfsh_n;
	logic   iorq_s;
	logic   external_port;
	logic   dos_on;
	logic   vdos_off;
	logic   cpu_stall;
	logic   ide_stall;
	logic   zpos;
	logic   zneg;
	logic   zclk_out;

	int errors = 0;
	int test_errors_at = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	logic prev_zclk = 1'b0;
	logic prev_zpos = 1'b0;
	logic prev_zneg = 1'b0;

	zclk_top DUT (
		.clk           (clk),
		.arst_n        (arst_n),
		.turbo_req     (turbo_req),
		.rfsh_n        (rfsh_n),
		.iorq_s        (iorq_s),
		.external_port (external_port),
		.dos_on        (dos_on),
		.vdos_off      (vdos_off),
		.cpu_stall     (cpu_stall),
		.ide_stall     (ide_stall),
		.zpos          (zpos),
		.zneg          (zneg),
		.zclk_out      (zclk_out)
	);

	// 28 MHz stand-in, 40 ns period
	always #20 clk = ~clk;

	task automatic check_eq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR: %s got %h expected %h at %0t", name, actual, expected, $time);
			errors++;
		end
	endtask

	// strobe vs clock level, sampled after each rising edge
	always @(posedge clk)
	begin
		#5;
		if (arst_n)
		begin
			if (zpos)
				check_eq("zclk_out with zpos", 32'(zclk_out), 1);
			if (zneg)
				check_eq("zclk_out with zneg", 32'(zclk_out), 0);
			// a level change needs the matching strobe one sample earlier
			if (zclk_out != prev_zclk && !(zclk_out ? prev_zneg : prev_zpos))
			begin
				$display("zclk_out changed without a strobe at %0t", $time);
				errors++;
			end
		end
		prev_zclk = zclk_out;
		prev_zpos = zpos;
		prev_zneg = zneg;
	end

	// cycles until the next zpos, zneg seen on the way
	task automatic wait_zpos(output int n, output int negs, output int neg_at);
		int cnt;
		cnt = 0;
		n = -1;
		negs = 0;
		neg_at = -1;
		while (n < 0 && cnt < zpos_timeout)
		begin
			@(posedge clk);
			#5;
			cnt++;
			if (zpos)
				n = cnt;
			else if (zneg)
			begin
				negs++;
				neg_at = cnt;
			end
		end
		if (n < 0)
		begin
			$display("timeout: no zpos within %0d cycles at %0t", zpos_timeout, $time);
			errors++;
		end
	endtask

	// free running: one zneg exactly halfway between two zpos
	task automatic check_spacing(input int expected);
		int gap;
		int negs;
		int neg_at;
		wait_zpos(gap, negs, neg_at);
		wait_zpos(gap, negs, neg_at);
		check_eq("zpos gap", gap, expected);
		check_eq("zneg count", negs, 1);
		check_eq("zneg position", neg_at, expected / 2);
	endtask

	// request a mode, pulse rfsh_n low, let the old rhythm drain
	task automatic apply_turbo(input turbo_t mode);
		int n;
		int negs;
		int neg_at;
		@(negedge clk);
		turbo_req = mode;
		rfsh_n = 1'b0;
		@(negedge clk);
		rfsh_n = 1'b1;
		wait_zpos(n, negs, neg_at);
		wait_zpos(n, negs, neg_at);
	endtask

	// one-cycle pulse on {vdos_off, dos_on, external_port, iorq_s} after a zpos
	task automatic stall_pulse_gap(input logic [3:0] sel, output int gap);
		int n;
		int negs;
		int neg_at;
		wait_zpos(n, negs, neg_at);
		@(negedge clk);
		{vdos_off, dos_on, external_port, iorq_s} = sel;
		@(negedge clk);
		{vdos_off, dos_on, external_port, iorq_s} = 4'b0000;
		// one rising edge already passed since that zpos
		wait_zpos(n, negs, neg_at);
		gap = n + 1;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors_at)
		begin
			$display("test %s: ok", name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, errors - test_errors_at);
			tests_failed++;
		end
		test_errors_at = errors;
	endtask

	task automatic test_reset_35();
		check_eq("zclk_out", 32'(zclk_out), 0);
		check_eq("zpos", 32'(zpos), 0);
		check_eq("zneg", 32'(zneg), 0);
		check_spacing(8);
		check_spacing(8);
		end_test("reset and 3.5 MHz");
	endtask

	task automatic test_speeds();
		apply_turbo(2'b01);
		check_spacing(4);
		apply_turbo(2'b10);
		check_spacing(2);
		end_test("7 and 14 MHz");
	endtask

	task automatic test_refresh_only();
		// new request without refresh, 14 MHz must stay
		@(negedge clk);
		turbo_req = 2'b00;
		check_spacing(2);
		check_spacing(2);
		apply_turbo(2'b00);
		check_spacing(8);
		end_test("turbo at refresh only");
	endtask

	task automatic test_ext_stall();
		int delay;
		int len;
		int n;
		int negs;
		int neg_at;
		logic held;
		for (int i = 0; i < 4; i++)
		begin
			delay = $urandom_range(12, 1);
			len = $urandom_range(12, 2);
			repeat (delay) @(negedge clk);
			if (i % 2 == 1)
				ide_stall = 1'b1;
			else
				cpu_stall = 1'b1;
			@(posedge clk);
			#5;
			held = zclk_out;
			for (int k = 0; k < len; k++)
			begin
				if (k > 0)
				begin
					@(posedge clk);
					#5;
				end
				check_eq("zpos in stall", 32'(zpos), 0);
				check_eq("zneg in stall", 32'(zneg), 0);
				check_eq("zclk_out in stall", 32'(zclk_out), 32'(held));
			end
			@(negedge clk);
			cpu_stall = 1'b0;
			ide_stall = 1'b0;
			// strobes come back
			wait_zpos(n, negs, neg_at);
		end
		end_test("external stalls");
	endtask

	task automatic test_dos_io();
		int gap;
		apply_turbo(2'b10);
		check_spacing(2);
		stall_pulse_gap(4'b0100, gap);
		if (gap < 2 + (8 - int'(DOS_STALL_LOAD)))
		begin
			$display("dos_on stall too short, zpos gap of %0d cycles", gap);
			errors++;
		end
		stall_pulse_gap(4'b1000, gap);
		if (gap < 2 + (8 - int'(DOS_STALL_LOAD)))
		begin
			$display("vdos_off stall too short, zpos gap of %0d cycles", gap);
			errors++;
		end
		stall_pulse_gap(4'b0011, gap);
		if (gap < 2 + (8 - int'(IO_STALL_LOAD)))
		begin
			$display("external i/o stall too short, zpos gap of %0d cycles", gap);
			errors++;
		end
		// internal port, no stall
		stall_pulse_gap(4'b0001, gap);
		check_eq("zpos gap internal io", gap, 2);
		check_spacing(2);
		end_test("dos and i/o stalls");
	endtask

	initial
	begin
		void'($urandom(32'h7b62));
		arst_n = 1'b0;
		turbo_req = 2'b00;
		rfsh_n = 1'b1;
		iorq_s = 1'b0;
		external_port = 1'b0;
		dos_on = 1'b0;
		vdos_off = 1'b0;
		cpu_stall = 1'b0;
		ide_stall = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_reset_35();
		test_speeds();
		test_refresh_only();
		test_ext_stall();
		test_dos_io();
		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- turbo_sel.sv
// turbo selector
// holds the active cpu speed mode; a new request is applied only
// at a falling edge of rfsh_n, so the speed never changes in the
// middle of a bus cycle

`timescale 1ns/1ps

module turbo_sel
	import zclk_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  turbo_t turbo_req,
	input  logic   rfsh_n,
	output turbo_t turbo
);

	// rfsh_n from previous edge
	logic rfsh_n_prev;
	logic rfsh_fall;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rfsh_n_prev <= 1'b1;
		else
			rfsh_n_prev <= rfsh_n;
	end

	// high then low on consecutive edges
	assign rfsh_fall = rfsh_n_prev && !rfsh_n;

	// active mode, 3.5 MHz out of reset
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			turbo <= 2'b00;
		else if (rfsh_fall)
			turbo <= turbo_req;
	end

endmodule

//--- wait_gen.sv
// wait generator
// fixed stalls for dos mode switches and for external i/o in 14 MHz
// mode, merged with the external memory and ide stall levels into
// the single stall level for the z80 clock generator

`timescale 1ns/1ps

module wait_gen
	import zclk_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  turbo_t turbo,
	input  logic   iorq_s,
	input  logic   external_port,
	input  logic   dos_on,
	input  logic   vdos_off,
	input  logic   cpu_stall,
	input  logic   ide_stall,
	output logic   stall
);

	stall_cnt_t stall_cnt;
	logic       dos_stall;
	logic       io_stall;
	logic       stall_start;
	logic       cnt_end;

	// triggers
	assign dos_stall   = dos_on || vdos_off;
	// external port access, 14 MHz only
	assign io_stall    = iorq_s && external_port && turbo[1];
	assign stall_start = dos_stall || io_stall;
	assign cnt_end     = stall_cnt[3];

	// stall length counter, parked at end when idle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			stall_cnt <= STALL_CNT_END;
		else if (stall_start)
		begin
			// dos wins over i/o
			if (dos_stall)
				stall_cnt <= DOS_STALL_LOAD;
			else
				stall_cnt <= IO_STALL_LOAD;
		end
		else if (!cnt_end)
			stall_cnt <= stall_cnt + 4'd1;
	end

	// trigger cycle itself already stalls
	assign stall = stall_start || !cnt_end || cpu_stall || ide_stall;

	// counter stops at its end value
	a_cnt_no_overrun: assert property (
		@(posedge clk) disable iff (!arst_n)
		stall_cnt <= STALL_CNT_END
	);

	// dos switch holds the clock for a full 7 MHz cycle
	a_dos_stall_len: assert property (
		@(posedge clk) disable iff (!arst_n)
		dos_stall |=> stall [*4]
	);

endmodule

//--- zclk_pkg.sv
// z80 clock subsystem shared definitions
// speed mode encoding, stall counter width and stall lengths
// for the 28 MHz phase scheme

package zclk_pkg;

	// speed mode
	// 2'b00 3.5 MHz, 2'b01 7 MHz, 2'b1x 14 MHz
	typedef logic [1:0] turbo_t;

	// stall counter, ended when top bit set
	typedef logic [3:0] stall_cnt_t;

	// idle value, counter parked at its end
	localparam stall_cnt_t STALL_CNT_END = 4'd8;

	// 4 to 8, four clk cycles = one 7 MHz cycle
	localparam stall_cnt_t DOS_STALL_LOAD = 4'd4;

	// 0 to 8, eight clk cycles = one 3.5 MHz cycle
	localparam stall_cnt_t IO_STALL_LOAD = 4'd0;

endpackage

//--- zclk_top.sv
// z80 clock subsystem top level
// phase generator, turbo selector, wait generator and z80 clock
// generator for a 28 MHz system clock

`timescale 1ns/1ps

module zclk_top
	import zclk_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  turbo_t turbo_req,
	input  logic   rfsh_n,
	input  logic   iorq_s,
	input  logic   external_port,
	input  logic   dos_on,
	input  logic   vdos_off,
	input  logic   cpu_stall,
	input  logic   ide_stall,
	output logic   zpos,
	output logic   zneg,
	output logic   zclk_out
);

	// active speed mode and merged stall level
	turbo_t turbo;
	logic   stall;

	// c0..c3 to the clock generator
	phase_if ph ();

	clk_phase_gen u_phase (
		.clk    (clk),
		.arst_n (arst_n),
		.ph     (ph.src)
	);

	turbo_sel u_turbo (
		.clk       (clk),
		.arst_n    (arst_n),
		.turbo_req (turbo_req),
		.rfsh_n    (rfsh_n),
		.turbo     (turbo)
	);

	wait_gen u_wait (
		.clk           (clk),
		.arst_n        (arst_n),
		.turbo         (turbo),
		.iorq_s        (iorq_s),
		.external_port (external_port),
		.dos_on        (dos_on),
		.vdos_off      (vdos_off),
		.cpu_stall     (cpu_stall),
		.ide_stall     (ide_stall),
		.stall         (stall)
	);

	zclock u_zclock (
		.clk      (clk),
		.arst_n   (arst_n),
		.ph       (ph.dst),
		.turbo    (turbo),
		.stall    (stall),
		.zpos     (zpos),
		.zneg     (zneg),
		.zclk_out (zclk_out)
	);

endmodule

//--- zclock.sv
// z80 clock generator
// turns the phase strobes, the speed mode and the stall level into
// the registered edge strobes zpos/zneg and the z80 clock itself
// zclk_out changes on the falling edge of clk, half a clk cycle
// after the strobe that caused it

`timescale 1ns/1ps

module zclock
	import zclk_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	phase_if.dst   ph,
	input  turbo_t turbo,
	input  logic   stall,
	output logic   zpos,
	output logic   zneg,
	output logic   zclk_out
);

	logic clk14_src;
	logic c2_cnt;
	logic pre_zpos;
	logic pre_zneg;
	logic pre_zpos_140;
	logic pre_zneg_140;
	logic pre_zpos_70;
	logic pre_zneg_70;
	logic pre_zpos_35;
	logic pre_zneg_35;

	// 14 MHz source, frozen while stalled
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			clk14_src <= 1'b0;
		else if (!stall)
			clk14_src <= ~clk14_src;
	end

	assign pre_zpos_140 = clk14_src;
	assign pre_zneg_140 = ~clk14_src;

	// 7 MHz: rising edge on c2, falling on c0
	assign pre_zpos_70 = ph.c2;
	assign pre_zneg_70 = ph.c0;

	// halves c2 for 3.5 MHz
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			c2_cnt <= 1'b0;
		else if (ph.c2)
			c2_cnt <= ~c2_cnt;
	end

	// 3.5 MHz: c2 alternates between zpos and zneg
	assign pre_zpos_35 = c2_cnt && ph.c2;
	assign pre_zneg_35 = !c2_cnt && ph.c2;

	// mode select, top bit means 14 MHz
	always_comb
	begin
		if (turbo[1])
		begin
			pre_zpos = pre_zpos_140;
			pre_zneg = pre_zneg_140;
		end
		else if (turbo[0])
		begin
			pre_zpos = pre_zpos_70;
			pre_zneg = pre_zneg_70;
		end
		else
		begin
			pre_zpos = pre_zpos_35;
			pre_zneg = pre_zneg_35;
		end
	end

	// edge strobes, only toward the opposite clock level
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= !stall && pre_zpos && zclk_out;
			zneg <= !stall && pre_zneg && !zclk_out;
		end
	end

	// z80 clock, half a cycle after the strobe
	// zpos drops it, zneg raises it
	always_ff @(negedge clk or negedge arst_n)
	begin
		if (!arst_n)
			zclk_out <= 1'b0;
		else if (zneg)
			zclk_out <= 1'b1;
		else if (zpos)
			zclk_out <= 1'b0;
	end

	a_strobe_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(zpos && zneg)
	);

	// a stalled cycle gives no edge and the z80 clock keeps its level
	a_stall_no_strobe: assert property (
		@(posedge clk) disable iff (!arst_n)
		stall |=> !(zpos || zneg) && $stable(zclk_out)
	);

endmodule
